// File: Makefile
# Verilator build and run for the fetch unit testbench
VERILATOR ?= verilator
TOP       ?= tb_fetch_unit
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
# Keep running after a failed assertion so the summary is printed
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/fetch_fsm.sv
`default_nettype none

module fetch_fsm (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic redirect,
    input  logic hit,
    input  logic full,
    input  logic mem_rsp_valid,
    input  logic last_word,
    output logic advance,
    output logic refill_start,
    output logic refill_active
);
    import fetch_pkg::*;

    fetch_state_e state;
    fetch_state_e state_next;

    always_comb
    begin
        state_next   = state;
        advance      = 1'b0;
        refill_start = 1'b0;
        case (state)
            FS_LOOKUP:
            begin
                if (!hit)
                begin
                    // Miss at the current PC, fetch the whole line
                    refill_start = 1'b1;
                    state_next   = FS_REFILL;
                end
                else if (!full && !redirect)
                begin
                    advance = 1'b1;
                end
            end
            FS_REFILL:
            begin
                // Line is written on the final word, retry lookup next cycle
                if (mem_rsp_valid && last_word)
                begin
                    state_next = FS_LOOKUP;
                end
            end
            default:
            begin
                state_next = FS_LOOKUP;
            end
        endcase
    end

    assign refill_active = (state == FS_REFILL);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= FS_LOOKUP;
        end
        else if (rdy)
        begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Datapath widths
    localparam int ADDR_W = 32;
    localparam int INST_W = 32;

    // Direct-mapped cache geometry
    localparam int LINE_WORDS  = 4;
    localparam int CACHE_LINES = 16;
    localparam int OFFS_W      = $clog2(LINE_WORDS);
    localparam int INDEX_W     = $clog2(CACHE_LINES);
    // Two byte bits sit below the word offset
    localparam int TAG_W       = ADDR_W - INDEX_W - OFFS_W - 2;

    // Fetch queue
    localparam int FQ_DEPTH = 8;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [INST_W-1:0] inst;
    } fetch_entry_t;

    // Line request towards the word-serial memory
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [INST_W-1:0] data;
    } mem_rsp_t;

    typedef enum logic {
        FS_LOOKUP,
        FS_REFILL
    } fetch_state_e;

    // RISC-V major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_OTHER  = 7'b0000000
    } opcode_e;

endpackage

`default_nettype wire

// File: hdl/fetch_queue.sv
`default_nettype none

module fetch_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdy,
    input  logic                    flush,
    input  logic                    push,
    input  fetch_pkg::fetch_entry_t push_entry,
    input  logic                    rob_full,
    output logic                    full,
    output logic                    issue_valid,
    output fetch_pkg::fetch_entry_t issue_entry
);
    import fetch_pkg::*;

    fetch_entry_t        mem [FQ_DEPTH];
    logic [FQ_PTR_W-1:0] rd_ptr;
    logic [FQ_PTR_W-1:0] wr_ptr;
    logic                empty;
    logic                wr_en;
    logic                rd_en;

    // Protected strobes, never push when full or pop when empty
    assign wr_en = push && !full;
    assign rd_en = !empty && !rob_full;

    always_ff @(posedge clk)
    begin
        if (rst || (rdy && flush))
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end
        else if (rdy)
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en)
            begin
                empty <= 1'b0;
                // Last free slot taken
                full  <= (FQ_PTR_W'(wr_ptr + 1'b1) == rd_ptr);
            end
            else if (rd_en && !wr_en)
            begin
                full  <= 1'b0;
                empty <= (FQ_PTR_W'(rd_ptr + 1'b1) == wr_ptr);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rdy && wr_en && !flush)
        begin
            mem[wr_ptr] <= push_entry;
        end
    end

    assign issue_valid = rd_en;
    assign issue_entry = mem[rd_ptr];

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         redirect,
    input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
    output fetch_pkg::mem_req_t          mem_req_o,
    input  fetch_pkg::mem_rsp_t          mem_rsp_i,
    input  logic                         rob_full,
    output logic                         issue_valid,
    output fetch_pkg::fetch_entry_t      issue_entry
);
    import fetch_pkg::*;

    logic              hit;
    logic [INST_W-1:0] hit_inst;
    logic              advance;
    logic              refill_start;
    logic              refill_active;
    logic [OFFS_W-1:0] word_idx;
    logic              last_word;
    logic              full;
    logic [ADDR_W-1:0] pc;
    fetch_entry_t      push_entry;

    assign push_entry = '{pc: pc, inst: hit_inst};

    fetch_fsm fsm0 (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .redirect      (redirect),
        .hit           (hit),
        .full          (full),
        .mem_rsp_valid (mem_rsp_i.valid),
        .last_word     (last_word),
        .advance       (advance),
        .refill_start  (refill_start),
        .refill_active (refill_active)
    );

    refill_counter cnt0 (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .refill_start  (refill_start),
        .mem_rsp_valid (mem_rsp_i.valid),
        .word_idx      (word_idx),
        .last_word     (last_word)
    );

    icache_array ic0 (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .pc            (pc),
        .refill_start  (refill_start),
        .refill_active (refill_active),
        .word_idx      (word_idx),
        .mem_rsp_i     (mem_rsp_i),
        .hit           (hit),
        .hit_inst      (hit_inst),
        .mem_req_o     (mem_req_o)
    );

    pc_gen pcg0 (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .advance     (advance),
        .hit_inst    (hit_inst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    // Redirect flushes everything fetched on the old path
    fetch_queue fq0 (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush       (redirect),
        .push        (advance),
        .push_entry  (push_entry),
        .rob_full    (rob_full),
        .full        (full),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry)
    );

endmodule

`default_nettype wire

// File: hdl/icache_array.sv
`default_nettype none

module icache_array (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rdy,
    input  logic [fetch_pkg::ADDR_W-1:0]     pc,
    input  logic                             refill_start,
    input  logic                             refill_active,
    input  logic [fetch_pkg::OFFS_W-1:0]     word_idx,
    input  fetch_pkg::mem_rsp_t              mem_rsp_i,
    output logic                             hit,
    output logic [fetch_pkg::INST_W-1:0]     hit_inst,
    output fetch_pkg::mem_req_t              mem_req_o
);
    import fetch_pkg::*;

    logic [CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_mem  [CACHE_LINES];
    logic [INST_W-1:0]      data_mem [CACHE_LINES*LINE_WORDS];

    logic [INDEX_W-1:0] pc_index;
    logic [OFFS_W-1:0]  pc_offs;
    logic [TAG_W-1:0]   pc_tag;

    // Line being refilled, latched when the miss is seen
    logic [INDEX_W-1:0] refill_index;
    logic [TAG_W-1:0]   refill_tag;
    mem_req_t           mem_req_q;
    logic               word_wr;
    logic               line_done;

    assign pc_offs  = pc[2 +: OFFS_W];
    assign pc_index = pc[OFFS_W+2 +: INDEX_W];
    assign pc_tag   = pc[ADDR_W-1 -: TAG_W];

    // Combinational read at the current PC
    assign hit      = valid_q[pc_index] && (tag_mem[pc_index] == pc_tag);
    assign hit_inst = data_mem[{pc_index, pc_offs}];

    assign word_wr   = refill_active && mem_rsp_i.valid;
    assign line_done = word_wr && (word_idx == OFFS_W'(LINE_WORDS - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q       <= '0;
            mem_req_q.req <= 1'b0;
        end
        else if (rdy)
        begin
            if (refill_start)
            begin
                // Old line is dropped while the new one streams in
                valid_q[pc_index] <= 1'b0;
                mem_req_q.req     <= 1'b1;
            end
            else if (line_done)
            begin
                valid_q[refill_index] <= 1'b1;
                mem_req_q.req         <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rdy)
        begin
            if (refill_start)
            begin
                refill_index   <= pc_index;
                refill_tag     <= pc_tag;
                mem_req_q.addr <= {pc[ADDR_W-1:OFFS_W+2], {(OFFS_W+2){1'b0}}};
            end
            if (word_wr)
            begin
                data_mem[{refill_index, word_idx}] <= mem_rsp_i.data;
            end
            if (line_done)
            begin
                tag_mem[refill_index] <= refill_tag;
            end
        end
    end

    assign mem_req_o = mem_req_q;

endmodule

`default_nettype wire

// File: hdl/pc_gen.sv
`default_nettype none

module pc_gen (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         advance,
    input  logic [fetch_pkg::INST_W-1:0] hit_inst,
    input  logic                         redirect,
    input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
    output logic [fetch_pkg::ADDR_W-1:0] pc
);
    import fetch_pkg::*;

    opcode_e           opcode;
    logic [ADDR_W-1:0] jal_imm;
    logic [ADDR_W-1:0] pc_next;

    assign opcode = opcode_e'(hit_inst[6:0]);

    // J-type immediate, sign extended from bit 31
    assign jal_imm = {{(ADDR_W-20){hit_inst[31]}},
                      hit_inst[19:12],
                      hit_inst[20],
                      hit_inst[30:21],
                      1'b0};

    always_comb
    begin
        pc_next = pc;
        if (redirect)
        begin
            pc_next = redirect_pc;
        end
        else if (advance)
        begin
            // JAL target is known at fetch, take it now
            if (opcode == OP_JAL)
            begin
                pc_next = pc + jal_imm;
            end
            else
            begin
                pc_next = pc + ADDR_W'(4);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= '0;
        end
        else if (rdy)
        begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/refill_counter.sv
`default_nettype none

module refill_counter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rdy,
    input  logic                           refill_start,
    input  logic                           mem_rsp_valid,
    output logic [fetch_pkg::OFFS_W-1:0]   word_idx,
    output logic                           last_word
);
    import fetch_pkg::*;

    // Words arrive in order from the line base
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            word_idx <= '0;
        end
        else if (rdy)
        begin
            if (refill_start)
            begin
                word_idx <= '0;
            end
            else if (mem_rsp_valid)
            begin
                // Wraps to zero after the final word
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    assign last_word = (word_idx == OFFS_W'(LINE_WORDS - 1));

endmodule

`default_nettype wire

// File: verif/fetch_unit_chk.sv
`default_nettype none

module fetch_unit_chk (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         redirect,
    input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
    input  fetch_pkg::mem_req_t          mem_req_o,
    input  fetch_pkg::mem_rsp_t          mem_rsp_i,
    input  logic                         rob_full,
    input  logic                         issue_valid,
    input  fetch_pkg::fetch_entry_t      issue_entry
);
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    logic [ADDR_W-1:0] exp_pc;
    logic [2:0]        quiet_cnt;
    logic [OFFS_W:0]   words_got;
    logic              armed = 1'b0;
    logic              consume;
    logic              last_accept;
    int unsigned       fail_cnt = 0;

    // Next PC on the program path from the J-type immediate of a JAL
    function automatic logic [ADDR_W-1:0] next_pc(input logic [ADDR_W-1:0] pc,
                                                  input logic [INST_W-1:0] inst);
        logic [ADDR_W-1:0] offs;
        offs = {{(ADDR_W-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        if (inst[6:0] == OP_JAL)
        begin
            return pc + offs;
        end
        return pc + 32'd4;
    endfunction

    assign consume     = issue_valid && rdy;
    assign last_accept = mem_req_o.req && mem_rsp_i.valid && rdy
                         && (words_got == (OFFS_W+1)'(LINE_WORDS - 1));

    always_ff @(posedge clk)
    begin
        armed <= 1'b1;
        if (rst)
        begin
            exp_pc    <= '0;
            quiet_cnt <= 3'd4;
        end
        else
        begin
            if (quiet_cnt != 3'd0)
            begin
                quiet_cnt <= quiet_cnt - 3'd1;
            end
            if (rdy && redirect)
            begin
                exp_pc <= redirect_pc;
            end
            else if (consume)
            begin
                exp_pc <= next_pc(exp_pc, issue_entry.inst);
            end
        end
    end

    // Words accepted for the request now open
    always_ff @(posedge clk)
    begin
        if (rst || !mem_req_o.req)
        begin
            words_got <= '0;
        end
        else if (rdy && mem_rsp_i.valid)
        begin
            words_got <= words_got + 1'b1;
        end
    end

    a_rob_full: assert property (@(posedge clk) issue_valid |-> !rob_full)
    else
    begin
        $error("issue_valid high while rob_full is high");
        fail_cnt = fail_cnt + 1;
    end

    a_quiet: assert property (@(posedge clk)
        armed && (rst || quiet_cnt != 3'd0) |-> !issue_valid)
    else
    begin
        $error("issue_valid high during or right after reset");
        fail_cnt = fail_cnt + 1;
    end

    a_path: assert property (@(posedge clk) disable iff (rst)
        consume |-> issue_entry.pc == exp_pc)
    else
    begin
        $error("[ERROR] %0t issue_entry.pc: expected %h, got %h",
               $time, $sampled(exp_pc), $sampled(issue_entry.pc));
        fail_cnt = fail_cnt + 1;
    end

    a_align: assert property (@(posedge clk)
        mem_req_o.req |-> mem_req_o.addr[OFFS_W+1:0] == '0)
    else
    begin
        $error("memory request address is not line aligned");
        fail_cnt = fail_cnt + 1;
    end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_o.req && !last_accept |=> mem_req_o.req && $stable(mem_req_o.addr))
    else
    begin
        $error("memory request dropped or changed before the line completed");
        fail_cnt = fail_cnt + 1;
    end

    a_release: assert property (@(posedge clk) disable iff (rst)
        last_accept |=> !mem_req_o.req)
    else
    begin
        $error("memory request still high after the last word of the line");
        fail_cnt = fail_cnt + 1;
    end

endmodule

`default_nettype wire

// File: verif/tb_fetch_unit.sv
`default_nettype none

module tb_fetch_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    localparam int FREE_CYCLES  = 250;
    localparam int ROB_CYCLES   = 150;
    localparam int REDIR_CYCLES = 200;
    localparam int RDY_CYCLES   = 150;
    localparam int TIMEOUT = 4 * (FREE_CYCLES + ROB_CYCLES + REDIR_CYCLES + RDY_CYCLES);

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              redirect;
    logic [ADDR_W-1:0] redirect_pc;
    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    logic              rob_full;
    logic              issue_valid;
    fetch_entry_t      issue_entry;

    int unsigned            err_cnt = 0;
    int unsigned            cycle_cnt = 0;
    logic [ADDR_W-1:0]      line_addr [CACHE_LINES];
    logic [CACHE_LINES-1:0] line_seen = '0;
    logic                   req_q = 1'b0;

    fetch_unit dut0 (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp),
        .rob_full    (rob_full),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry)
    );

    bind fetch_unit fetch_unit_chk chk0 (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i),
        .rob_full    (rob_full),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry)
    );

    // Program image that loops inside every 128-byte block
    function automatic logic [INST_W-1:0] program_word(input logic [ADDR_W-1:0] a);
        logic [20:0] offs;
        offs = 21'h1fff84;
        if (a[6:2] == 5'd31)
        begin
            // jal x0, -124
            return {offs[20], offs[10:1], offs[11], offs[19:12], 5'd0, 7'b1101111};
        end
        // addi x1, x0, a[11:2]
        return {2'b00, a[11:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic pulse_redirect(input logic [ADDR_W-1:0] target);
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #1 redirect = 1'b0;
    endtask

    task automatic report_and_finish(input logic timed_out);
        int unsigned total;
        total = err_cnt + dut0.chk0.fail_cnt + (timed_out ? 32'd1 : 32'd0);
        $display("Summary: %0d issue errors, %0d assertion failures, %0d timeouts",
                 err_cnt, dut0.chk0.fail_cnt, timed_out);
        if (total == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Word-serial memory holds valid until a cycle with rdy high takes it
    initial
    begin : memory_model
        logic              busy;
        logic              taken;
        int unsigned       word_cnt;
        logic [1:0]        gap;
        logic [ADDR_W-1:0] base;
        logic [31:0]       mseed;
        busy     = 1'b0;
        word_cnt = 0;
        gap      = 2'd0;
        base     = '0;
        mseed    = 32'hfb1f;
        mem_rsp  = '0;
        forever
        begin
            @(posedge clk);
            taken = mem_rsp.valid && rdy;
            #1;
            if (taken)
            begin
                mem_rsp.valid = 1'b0;
                word_cnt      = word_cnt + 1;
                mseed         = lcg_next(mseed);
                gap           = mseed[17:16];
                busy          = (word_cnt < LINE_WORDS);
            end
            if (!busy && mem_req.req)
            begin
                busy     = 1'b1;
                base     = mem_req.addr;
                word_cnt = 0;
                mseed    = lcg_next(mseed);
                gap      = mseed[17:16];
            end
            if (busy && !mem_rsp.valid)
            begin
                if (gap == 2'd0)
                begin
                    mem_rsp.valid = 1'b1;
                    mem_rsp.data  = program_word(base + ADDR_W'(word_cnt * 4));
                end
                else
                    gap = gap - 2'd1;
            end
        end
    end

    // Issue port content and repeated line requests
    always @(posedge clk)
    begin
        logic [INDEX_W-1:0] idx;
        idx   = mem_req.addr[OFFS_W+2 +: INDEX_W];
        req_q <= mem_req.req;
        if (!rst && issue_valid && rdy && issue_entry.inst !== program_word(issue_entry.pc))
        begin
            $display("[ERROR] %0t issue_entry.inst: expected %h, got %h",
                     $time, program_word(issue_entry.pc), issue_entry.inst);
            err_cnt = err_cnt + 1;
        end
        if (!rst && mem_req.req && !req_q)
        begin
            if (line_seen[idx] && line_addr[idx] == mem_req.addr)
            begin
                $display("Line at %h was requested again while it should be cached",
                         mem_req.addr);
                err_cnt = err_cnt + 1;
            end
            line_seen[idx] <= 1'b1;
            line_addr[idx] <= mem_req.addr;
        end
    end

    initial
    begin : watchdog
        while (cycle_cnt < TIMEOUT)
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: the test did not finish within %0d cycles", TIMEOUT);
        report_and_finish(1'b1);
    end

    initial
    begin : stimulus
        logic [31:0] seed;
        rst         = 1'b1;
        rdy         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        rob_full    = 1'b0;
        seed        = 32'hfb1f;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        // Two passes through block 0 with the second one from the cache
        repeat (FREE_CYCLES) @(posedge clk);

        repeat (ROB_CYCLES)
        begin
            @(posedge clk);
            #1;
            seed     = lcg_next(seed);
            rob_full = seed[24];
        end
        @(posedge clk);
        #1 rob_full = 1'b0;

        // Second redirect lands while the 0x200 line is refilling
        pulse_redirect(32'h200);
        while (!mem_req.req)
        begin
            @(posedge clk);
            #1;
        end
        pulse_redirect(32'h400);
        repeat (REDIR_CYCLES) @(posedge clk);

        repeat (2)
        begin
            #1 rdy = 1'b0;
            repeat (5) @(posedge clk);
            #1 rdy = 1'b1;
            repeat (RDY_CYCLES / 2) @(posedge clk);
        end
        // Checks on the last edge finish before the summary
        #1;
        report_and_finish(1'b0);
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/fetch_pkg.sv
hdl/fetch_fsm.sv
hdl/refill_counter.sv
hdl/icache_array.sv
hdl/pc_gen.sv
hdl/fetch_queue.sv
hdl/fetch_unit.sv
verif/fetch_unit_chk.sv
verif/tb_fetch_unit.sv
